/* Makefile */
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= coreTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FLIST)))
HEADERS := $(wildcard logic/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -qx 'Result: PASSED' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
+incdir+logic
logic/rvIsaPkg.sv
logic/pipePkg.sv
logic/fetchUnit.sv
logic/controlUnit.sv
logic/regFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/coreTop.sv
verif/coreTb.sv

/* logic/controlUnit.sv */
module controlUnit import rvIsaPkg::*, pipePkg::*; (
    input  instrWordT instr,
    output logic      regWrite,
    output aluOpT     aluOp,
    output logic      aluSrcImm,
    output immSrcT    immSrc,
    output logic      beq,
    output logic      bne,
    output logic      jump,
    output logic      jumpReg
);

    logic isSub;

    // funct7 bit 5 only selects SUB in the register form
    assign isSub = (instr.rFmt.opcode == opcReg) && instr.rFmt.funct7[5];

    always_comb begin
        regWrite  = 1'b0;
        aluOp     = aluAdd;
        aluSrcImm = 1'b0;
        immSrc    = immI;
        beq       = 1'b0;
        bne       = 1'b0;
        jump      = 1'b0;
        jumpReg   = 1'b0;
        case (instr.rFmt.opcode)
            opcReg, opcImm: begin
                regWrite  = 1'b1;
                aluSrcImm = (instr.rFmt.opcode == opcImm);
                case (instr.rFmt.funct3)
                    f3AddSub: aluOp = isSub ? aluSub : aluAdd;
                    f3Slt:    aluOp = aluSlt;
                    f3Xor:    aluOp = aluXor;
                    f3Or:     aluOp = aluOr;
                    f3And:    aluOp = aluAnd;
                    // Shifts and SLTU are not implemented
                    default:  regWrite = 1'b0;
                endcase
            end
            opcLui: begin
                regWrite  = 1'b1;
                aluOp     = aluPassB;
                aluSrcImm = 1'b1;
                immSrc    = immU;
            end
            opcBranch: begin
                immSrc = immB;
                beq    = (instr.rFmt.funct3 == f3Beq);
                bne    = (instr.rFmt.funct3 == f3Bne);
            end
            // Link value arrives as the immediate, ALU just passes it
            opcJal: begin
                regWrite  = 1'b1;
                aluOp     = aluPassB;
                aluSrcImm = 1'b1;
                immSrc    = immJ;
                jump      = 1'b1;
            end
            opcJalr: begin
                regWrite  = 1'b1;
                aluOp     = aluPassB;
                aluSrcImm = 1'b1;
                jumpReg   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* logic/coreTop.sv */
`include "core_defs.svh"

module coreTop import rvIsaPkg::*, pipePkg::*; (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            hold,
    input  logic                            romWe,
    input  logic [$clog2(`IMEM_DEPTH)-1:0]  romAddr,
    input  logic [`XLEN-1:0]                romData,
    output logic                            retireValid,
    output logic [$clog2(`NUM_REGS)-1:0]    retireRd,
    output logic [`XLEN-1:0]                retireData,
    output logic [`XLEN-1:0]                a0
);

    // Fetch to decode
    logic                           instrValid, creditReturn, redirect;
    instrWordT                      instrWord;
    logic [`XLEN-1:0]               instrPc, redirectPc;

    // Decode to execute
    logic                           issueValid, aluSrcImm, regWrite;
    aluOpT                          aluOp;
    logic [`XLEN-1:0]               opA, opB, imm;
    logic [$clog2(`NUM_REGS)-1:0]   rd;

    // Writeback
    logic                           regWriteW;
    logic [$clog2(`NUM_REGS)-1:0]   rdW;
    logic [`XLEN-1:0]               resultW;

    fetchUnit fetch (
        .clk(clk),
        .rstN(rstN),
        .romWe(romWe),
        .romAddr(romAddr),
        .romData(romData),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .creditReturn(creditReturn),
        .instrValid(instrValid),
        .instrWord(instrWord),
        .instrPc(instrPc)
    );

    decodeStage decode (
        .clk(clk),
        .rstN(rstN),
        .instrValid(instrValid),
        .instrWord(instrWord),
        .instrPc(instrPc),
        .hold(hold),
        .regWriteW(regWriteW),
        .rdW(rdW),
        .resultW(resultW),
        .creditReturn(creditReturn),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .issueValid(issueValid),
        .aluOp(aluOp),
        .aluSrcImm(aluSrcImm),
        .regWrite(regWrite),
        .opA(opA),
        .opB(opB),
        .imm(imm),
        .rd(rd),
        .a0(a0)
    );

    executeStage execute (
        .clk(clk),
        .rstN(rstN),
        .hold(hold),
        .issueValid(issueValid),
        .aluOp(aluOp),
        .aluSrcImm(aluSrcImm),
        .regWrite(regWrite),
        .opA(opA),
        .opB(opB),
        .imm(imm),
        .rd(rd),
        .regWriteW(regWriteW),
        .rdW(rdW),
        .resultW(resultW),
        .retireValid(retireValid),
        .retireRd(retireRd),
        .retireData(retireData)
    );

endmodule

/* logic/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data and instruction width
`define XLEN 32
// Architectural registers
`define NUM_REGS 32
// Instruction ROM words
`define IMEM_DEPTH 64
// Decode queue depth, also the fetch credit count out of reset
`define QUEUE_CREDITS 2

`endif

/* logic/decodeStage.sv */
`include "core_defs.svh"

module decodeStage import rvIsaPkg::*, pipePkg::*; (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          instrValid,
    input  instrWordT                     instrWord,
    input  logic [`XLEN-1:0]              instrPc,
    input  logic                          hold,
    input  logic                          regWriteW,
    input  logic [$clog2(`NUM_REGS)-1:0]  rdW,
    input  logic [`XLEN-1:0]              resultW,
    output logic                          creditReturn,
    output logic                          redirect,
    output logic [`XLEN-1:0]              redirectPc,
    output logic                          issueValid,
    output aluOpT                         aluOp,
    output logic                          aluSrcImm,
    output logic                          regWrite,
    output logic [`XLEN-1:0]              opA,
    output logic [`XLEN-1:0]              opB,
    output logic [`XLEN-1:0]              imm,
    output logic [$clog2(`NUM_REGS)-1:0]  rd,
    output logic [`XLEN-1:0]              a0
);

    localparam int QDepth = `QUEUE_CREDITS;
    localparam int PtrW   = $clog2(QDepth);
    localparam int CntW   = $clog2(QDepth + 1);
    localparam int RegAw  = $clog2(`NUM_REGS);

    instrWordT              qWord [QDepth];
    logic [`XLEN-1:0]       qPc [QDepth];
    logic [PtrW-1:0]        rdPtr, wrPtr;
    logic [CntW-1:0]        count;

    instrWordT              head;
    logic [`XLEN-1:0]       headPc;
    logic                   headValid, push, issue, hazard, taken;
    logic [RegAw-1:0]       rs1, rs2;

    logic                   regWriteD, aluSrcImmD, beqD, bneD, jumpD, jumpRegD;
    aluOpT                  aluOpD;
    immSrcT                 immSrc;

    logic [`XLEN-1:0]       rdata1, rdata2, fwdA, fwdB;
    logic [`XLEN-1:0]       immExt, pcPlus4, jalrSum;

    // Instruction queue is flushed on redirect without returning credits
    assign push      = instrValid && !redirect;
    assign headValid = (count != '0);
    assign head      = qWord[rdPtr];
    assign headPc    = qPc[rdPtr];

    always_ff @(posedge clk) begin
        if (!rstN || redirect) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (issue) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + CntW'(push) - CntW'(issue);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            qWord[wrPtr] <= instrWord;
            qPc[wrPtr]   <= instrPc;
        end
    end

    controlUnit ctrl (
        .instr(head),
        .regWrite(regWriteD),
        .aluOp(aluOpD),
        .aluSrcImm(aluSrcImmD),
        .immSrc(immSrc),
        .beq(beqD),
        .bne(bneD),
        .jump(jumpD),
        .jumpReg(jumpRegD)
    );

    assign rs1 = head.rFmt.rs1;
    assign rs2 = head.rFmt.rs2;

    regFile regs (
        .clk(clk),
        .rstN(rstN),
        .we(regWriteW),
        .waddr(rdW),
        .wdata(resultW),
        .raddr1(rs1),
        .raddr2(rs2),
        .rdata1(rdata1),
        .rdata2(rdata2),
        .a0(a0)
    );

    // Writeback result forwarded to matching source registers
    assign fwdA = (regWriteW && rdW == rs1) ? resultW : rdata1;
    assign fwdB = (regWriteW && rdW == rs2) ? resultW : rdata2;

    // Stall one cycle while the producer is still in execute
    assign hazard = issueValid && regWrite && rd != '0 && (rd == rs1 || rd == rs2);
    assign issue  = headValid && !hold && !hazard;

    always_comb begin
        case (immSrc)
            immB: immExt = {{19{head.bFmt.imm12}}, head.bFmt.imm12, head.bFmt.imm11,
                            head.bFmt.imm10to5, head.bFmt.imm4to1, 1'b0};
            immJ: immExt = {{11{head.jFmt.imm20}}, head.jFmt.imm20, head.jFmt.imm19to12,
                            head.jFmt.imm11, head.jFmt.imm10to1, 1'b0};
            // upper 20 bits sit in the J view in their natural order
            immU: immExt = {head.jFmt.imm20, head.jFmt.imm10to1, head.jFmt.imm11,
                            head.jFmt.imm19to12, 12'b0};
            default: immExt = {{20{head.iFmt.imm[11]}}, head.iFmt.imm};
        endcase
    end

    // Early branch and jump resolution at the queue head
    assign pcPlus4    = headPc + `XLEN'(4);
    assign jalrSum    = fwdA + immExt;
    assign taken      = (beqD && fwdA == fwdB) || (bneD && fwdA != fwdB) || jumpD || jumpRegD;
    assign redirect   = issue && taken;
    assign redirectPc = jumpRegD ? {jalrSum[`XLEN-1:1], 1'b0} : headPc + immExt;

    assign creditReturn = issue;

    // Execute pipeline register keeps its value while hold is high
    always_ff @(posedge clk) begin
        if (!rstN) begin
            issueValid <= 1'b0;
            regWrite   <= 1'b0;
        end else if (!hold) begin
            // Branches leave as bubbles
            issueValid <= issue && !(beqD || bneD);
            regWrite   <= regWriteD;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            aluOp     <= aluOpD;
            aluSrcImm <= aluSrcImmD;
            opA       <= fwdA;
            opB       <= fwdB;
            imm       <= (jumpD || jumpRegD) ? pcPlus4 : immExt;
            rd        <= head.rFmt.rd;
        end
    end

    // Fetch credits should make overflow impossible
    assert property (@(posedge clk) disable iff (!rstN)
        push |-> count < CntW'(QDepth))
        else $error("push into full decode queue");

endmodule

/* logic/executeStage.sv */
`include "core_defs.svh"

module executeStage import pipePkg::*; (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          hold,
    input  logic                          issueValid,
    input  aluOpT                         aluOp,
    input  logic                          aluSrcImm,
    input  logic                          regWrite,
    input  logic [`XLEN-1:0]              opA,
    input  logic [`XLEN-1:0]              opB,
    input  logic [`XLEN-1:0]              imm,
    input  logic [$clog2(`NUM_REGS)-1:0]  rd,
    output logic                          regWriteW,
    output logic [$clog2(`NUM_REGS)-1:0]  rdW,
    output logic [`XLEN-1:0]              resultW,
    output logic                          retireValid,
    output logic [$clog2(`NUM_REGS)-1:0]  retireRd,
    output logic [`XLEN-1:0]              retireData
);

    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluResult;

    assign srcB = aluSrcImm ? imm : opB;

    always_comb begin
        case (aluOp)
            aluSub:   aluResult = opA - srcB;
            aluAnd:   aluResult = opA & srcB;
            aluOr:    aluResult = opA | srcB;
            aluXor:   aluResult = opA ^ srcB;
            aluSlt:   aluResult = `XLEN'($signed(opA) < $signed(srcB));
            aluPassB: aluResult = srcB;
            default:  aluResult = opA + srcB;
        endcase
    end

    // Writes to x0 are dropped here so they never retire or forward
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWriteW <= 1'b0;
        end else begin
            regWriteW <= !hold && issueValid && regWrite && rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            rdW     <= rd;
            resultW <= aluResult;
        end
    end

    // Every register write is a retire
    assign retireValid = regWriteW;
    assign retireRd    = rdW;
    assign retireData  = resultW;

endmodule

/* logic/fetchUnit.sv */
`include "core_defs.svh"

module fetchUnit import rvIsaPkg::*; (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            romWe,
    input  logic [$clog2(`IMEM_DEPTH)-1:0]  romAddr,
    input  logic [`XLEN-1:0]                romData,
    input  logic                            redirect,
    input  logic [`XLEN-1:0]                redirectPc,
    input  logic                            creditReturn,
    output logic                            instrValid,
    output instrWordT                       instrWord,
    output logic [`XLEN-1:0]                instrPc
);

    localparam int RomAw   = $clog2(`IMEM_DEPTH);
    localparam int CreditW = $clog2(`QUEUE_CREDITS + 1);

    logic [`XLEN-1:0]   rom [`IMEM_DEPTH];
    logic [`XLEN-1:0]   pc;
    logic [CreditW-1:0] credits;
    logic               send;

    // Hold back while redirecting, the slot would carry a stale PC
    assign send = (credits != '0) && !redirect;

    // ROM loaded by the testbench, word addressed
    always_ff @(posedge clk) begin
        if (romWe) begin
            rom[romAddr] <= romData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc         <= '0;
            credits    <= CreditW'(`QUEUE_CREDITS);
            instrValid <= 1'b0;
        end else if (redirect) begin
            // Queue is flushed on the decode side, so all credits come back
            pc         <= redirectPc;
            credits    <= CreditW'(`QUEUE_CREDITS);
            instrValid <= 1'b0;
        end else begin
            instrValid <= send;
            if (send) begin
                pc <= pc + `XLEN'(4);
            end
            credits <= credits - CreditW'(send) + CreditW'(creditReturn);
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            instrWord <= rom[pc[RomAw+1:2]];
            instrPc   <= pc;
        end
    end

    // Decode must never hand back more credits than it was given
    assert property (@(posedge clk) disable iff (!rstN)
        credits <= CreditW'(`QUEUE_CREDITS))
        else $error("fetch credit count above queue depth");

endmodule

/* logic/pipePkg.sv */
package pipePkg;

    // Operation selected for the execute ALU
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluPassB
    } aluOpT;

    // Which instruction format the immediate comes from
    typedef enum logic [1:0] {
        immI,
        immB,
        immJ,
        immU
    } immSrcT;

endpackage

/* logic/regFile.sv */
`include "core_defs.svh"

module regFile (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          we,
    input  logic [$clog2(`NUM_REGS)-1:0]  waddr,
    input  logic [`XLEN-1:0]              wdata,
    input  logic [$clog2(`NUM_REGS)-1:0]  raddr1,
    input  logic [$clog2(`NUM_REGS)-1:0]  raddr2,
    output logic [`XLEN-1:0]              rdata1,
    output logic [`XLEN-1:0]              rdata2,
    output logic [`XLEN-1:0]              a0
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is never written, so it reads back as zero
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];
    assign a0     = regs[10];

endmodule

/* logic/rvIsaPkg.sv */
package rvIsaPkg;

    typedef enum logic [6:0] {
        opcReg    = 7'b0110011,
        opcImm    = 7'b0010011,
        opcLui    = 7'b0110111,
        opcBranch = 7'b1100011,
        opcJal    = 7'b1101111,
        opcJalr   = 7'b1100111
    } opcodeT;

    // ALU funct3 codes, shared by register and immediate forms
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // Branch funct3 codes
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFmtT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFmtT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bFmtT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jFmtT;

    // One instruction word, four ways of reading it
    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
        bFmtT bFmt;
        jFmtT jFmt;
    } instrWordT;

endpackage

/* verif/coreTb.sv */
`include "core_defs.svh"

module coreTb import rvIsaPkg::*, pipePkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RegAw       = $clog2(`NUM_REGS);
    localparam int RomAw       = $clog2(`IMEM_DEPTH);
    localparam int NumTests    = 7;
    localparam int MaxInstr    = 16;
    localparam int MaxRetire   = 16;
    // Quiet cycles after the last expected retire
    localparam int DrainCycles = 8;

    typedef logic [RegAw-1:0]   regIdxT;
    typedef logic [`XLEN-1:0]   wordT;

    logic               clk = 1'b0;
    logic               rstN;
    logic               hold;
    logic               romWe;
    logic [RomAw-1:0]   romAddr;
    wordT               romData;
    logic               retireValid;
    regIdxT             retireRd;
    wordT               retireData;
    wordT               a0;

    // Program table with one row per test
    string      testName [NumTests];
    bit         holdOn   [NumTests];
    instrWordT  prog     [NumTests][MaxInstr];
    int         progLen  [NumTests];
    regIdxT     expRd    [NumTests][MaxRetire];
    wordT       expData  [NumTests][MaxRetire];
    int         retCount [NumTests];
    wordT       expA0    [NumTests];
    int         cur;

    int         errorCount;
    int         retireChecks;
    int         watchLimit;
    bit         holdEnable;

    coreTop u_dut (
        .clk(clk),
        .rstN(rstN),
        .hold(hold),
        .romWe(romWe),
        .romAddr(romAddr),
        .romData(romData),
        .retireValid(retireValid),
        .retireRd(retireRd),
        .retireData(retireData),
        .a0(a0)
    );

    always #50 clk = ~clk;

    // Instruction encoders following the RV32I formats
    function automatic instrWordT regOp(input logic [2:0] f3, input bit isSub,
                                        input int rd, input int rs1, input int rs2);
        instrWordT w;
        w.rFmt.funct7 = isSub ? 7'b0100000 : 7'b0000000;
        w.rFmt.rs2    = 5'(rs2);
        w.rFmt.rs1    = 5'(rs1);
        w.rFmt.funct3 = f3;
        w.rFmt.rd     = 5'(rd);
        w.rFmt.opcode = opcReg;
        return w;
    endfunction

    function automatic instrWordT addi(input int rd, input int rs1, input int imm);
        instrWordT w;
        w.iFmt.imm    = 12'(imm);
        w.iFmt.rs1    = 5'(rs1);
        w.iFmt.funct3 = f3AddSub;
        w.iFmt.rd     = 5'(rd);
        w.iFmt.opcode = opcImm;
        return w;
    endfunction

    function automatic instrWordT jalr(input int rd, input int rs1, input int imm);
        instrWordT w;
        w.iFmt.imm    = 12'(imm);
        w.iFmt.rs1    = 5'(rs1);
        w.iFmt.funct3 = 3'b000;
        w.iFmt.rd     = 5'(rd);
        w.iFmt.opcode = opcJalr;
        return w;
    endfunction

    function automatic instrWordT lui(input int rd, input int upper);
        instrWordT w;
        w = {20'(upper), 5'(rd), opcLui};
        return w;
    endfunction

    function automatic instrWordT branch(input logic [2:0] f3, input int rs1, input int rs2,
                                         input int off);
        logic [12:0] o;
        instrWordT   w;
        o = 13'(off);
        w.bFmt.imm12    = o[12];
        w.bFmt.imm10to5 = o[10:5];
        w.bFmt.rs2      = 5'(rs2);
        w.bFmt.rs1      = 5'(rs1);
        w.bFmt.funct3   = f3;
        w.bFmt.imm4to1  = o[4:1];
        w.bFmt.imm11    = o[11];
        w.bFmt.opcode   = opcBranch;
        return w;
    endfunction

    function automatic instrWordT jal(input int rd, input int off);
        logic [20:0] o;
        instrWordT   w;
        o = 21'(off);
        w.jFmt.imm20     = o[20];
        w.jFmt.imm10to1  = o[10:1];
        w.jFmt.imm11     = o[11];
        w.jFmt.imm19to12 = o[19:12];
        w.jFmt.rd        = 5'(rd);
        w.jFmt.opcode    = opcJal;
        return w;
    endfunction

    task automatic startTest(input int t, input string name, input bit withHold,
                             input wordT a0Value);
        cur         = t;
        testName[t] = name;
        holdOn[t]   = withHold;
        expA0[t]    = a0Value;
        progLen[t]  = 0;
        retCount[t] = 0;
    endtask

    task automatic emit(input instrWordT w);
        prog[cur][progLen[cur]] = w;
        progLen[cur]++;
    endtask

    task automatic wantRetire(input int rd, input wordT data);
        expRd[cur][retCount[cur]]   = regIdxT'(rd);
        expData[cur][retCount[cur]] = data;
        retCount[cur]++;
    endtask

    // Counting loop used with and without back-pressure
    task automatic loopProgram();
        emit(addi(1, 0, 0));
        wantRetire(1, 0);
        emit(addi(2, 0, 4));
        wantRetire(2, 4);
        emit(addi(10, 0, 0));
        wantRetire(10, 0);
        emit(addi(1, 1, 1));
        emit(regOp(f3AddSub, 1'b0, 10, 10, 1));
        emit(branch(f3Bne, 1, 2, -8));
        for (int k = 1; k <= 4; k++) begin
            wantRetire(1, k);
            wantRetire(10, k * (k + 1) / 2);
        end
        emit(lui(3, 20'hABCDE));
        wantRetire(3, 32'hABCD_E000);
        emit(regOp(f3Xor, 1'b0, 4, 3, 10));
        wantRetire(4, 32'hABCD_E00A);
        emit(regOp(f3Slt, 1'b0, 5, 4, 0));
        wantRetire(5, 1);
        emit(regOp(f3AddSub, 1'b1, 10, 10, 5));
        wantRetire(10, 9);
        emit(jal(0, 0));
    endtask

    task automatic buildTable();
        startTest(0, "aluOps", 1'b0, 32'h1234_5000);
        emit(addi(1, 0, 5));
        wantRetire(1, 5);
        emit(addi(2, 0, -3));
        wantRetire(2, 32'hFFFF_FFFD);
        emit(regOp(f3AddSub, 1'b0, 3, 1, 2));
        wantRetire(3, 2);
        emit(regOp(f3AddSub, 1'b1, 4, 1, 2));
        wantRetire(4, 8);
        emit(regOp(f3And, 1'b0, 5, 1, 2));
        wantRetire(5, 5);
        emit(regOp(f3Or, 1'b0, 6, 1, 2));
        wantRetire(6, 32'hFFFF_FFFD);
        emit(regOp(f3Xor, 1'b0, 7, 1, 2));
        wantRetire(7, 32'hFFFF_FFF8);
        emit(regOp(f3Slt, 1'b0, 8, 2, 1));
        wantRetire(8, 1);
        emit(regOp(f3Slt, 1'b0, 9, 1, 2));
        wantRetire(9, 0);
        emit(lui(10, 20'h12345));
        wantRetire(10, 32'h1234_5000);
        emit(jal(0, 0));

        startTest(1, "forwarding", 1'b0, 32'd107);
        emit(addi(1, 0, 7));
        wantRetire(1, 7);
        emit(regOp(f3AddSub, 1'b0, 2, 1, 1));
        wantRetire(2, 14);
        emit(regOp(f3AddSub, 1'b0, 3, 2, 1));
        wantRetire(3, 21);
        emit(regOp(f3AddSub, 1'b1, 10, 3, 2));
        wantRetire(10, 7);
        emit(addi(10, 10, 100));
        wantRetire(10, 107);
        emit(jal(0, 0));

        // Taken BEQ skipping two, then untaken BNE, taken BNE and untaken BEQ
        startTest(2, "branches", 1'b0, 32'd42);
        emit(addi(1, 0, 1));
        wantRetire(1, 1);
        emit(addi(2, 0, 1));
        wantRetire(2, 1);
        emit(branch(f3Beq, 1, 2, 12));
        emit(addi(3, 0, 99));
        emit(addi(3, 0, 98));
        emit(branch(f3Bne, 1, 2, 8));
        emit(addi(4, 0, 4));
        wantRetire(4, 4);
        emit(branch(f3Bne, 1, 4, 8));
        emit(addi(5, 0, 55));
        emit(branch(f3Beq, 1, 4, 8));
        emit(addi(10, 0, 42));
        wantRetire(10, 42);
        emit(jal(0, 0));

        startTest(3, "jumps", 1'b0, 32'd27);
        emit(addi(1, 0, 1));
        wantRetire(1, 1);
        emit(jal(5, 12));
        wantRetire(5, 8);
        emit(addi(6, 0, 66));
        emit(addi(6, 0, 77));
        emit(addi(7, 0, 36));
        wantRetire(7, 36);
        // Target 37 with bit 0 cleared
        emit(jalr(8, 7, 1));
        wantRetire(8, 24);
        emit(addi(6, 0, 11));
        emit(addi(6, 0, 12));
        emit(addi(6, 0, 13));
        emit(addi(10, 8, 3));
        wantRetire(10, 27);
        emit(jal(0, 0));

        startTest(4, "zeroReg", 1'b0, 32'd9);
        emit(addi(0, 0, 5));
        emit(regOp(f3AddSub, 1'b0, 1, 0, 0));
        wantRetire(1, 0);
        emit(addi(2, 0, 9));
        wantRetire(2, 9);
        emit(regOp(f3AddSub, 1'b0, 0, 2, 2));
        emit(regOp(f3AddSub, 1'b0, 3, 0, 2));
        wantRetire(3, 9);
        emit(jal(0, 8));
        emit(addi(4, 0, 1));
        emit(regOp(f3Or, 1'b0, 10, 0, 3));
        wantRetire(10, 9);
        emit(jal(0, 0));

        startTest(5, "longLoop", 1'b0, 32'd9);
        loopProgram();
        startTest(6, "longLoopHold", 1'b1, 32'd9);
        loopProgram();
    endtask

    task automatic checkRetire(input string name, input int idx, input regIdxT wantRd,
                               input wordT wantData, input regIdxT gotRd, input wordT gotData);
        retireChecks++;
        if (gotRd !== wantRd || gotData !== wantData) begin
            $display("Error: %s retire %0d expected x%0d=%h, actual x%0d=%h",
                     name, idx, wantRd, wantData, gotRd, gotData);
            errorCount++;
        end
    endtask

    task automatic checkA0(input string name, input wordT wantA0, input wordT gotA0);
        if (gotA0 !== wantA0) begin
            $display("Error: %s a0 expected %h, actual %h", name, wantA0, gotA0);
            errorCount++;
        end
    endtask

    task automatic stepToDrive();
        @(posedge clk);
        #5;
    endtask

    // ROM is written while the core is held in reset
    // Unused words become ADDI x0 with their own address
    task automatic loadAndReset(input int t);
        stepToDrive();
        rstN = 1'b0;
        for (int a = 0; a < `IMEM_DEPTH; a++) begin
            stepToDrive();
            romWe   = 1'b1;
            romAddr = RomAw'(a);
            romData = (a < progLen[t]) ? prog[t][a] : addi(0, 0, a);
        end
        stepToDrive();
        romWe = 1'b0;
        repeat (2) stepToDrive();
        rstN = 1'b1;
    endtask

    task automatic runProgram(input int t);
        int got;
        int edges;
        got   = 0;
        edges = 0;
        @(negedge clk);
        holdEnable = holdOn[t];
        while (got < retCount[t]) begin
            @(negedge clk);
            edges++;
            if (retireValid) begin
                if (got == 0 && edges < 3) begin
                    $display("%s: first retire only %0d cycles after reset", testName[t], edges);
                    errorCount++;
                end
                checkRetire(testName[t], got, expRd[t][got], expData[t][got],
                            retireRd, retireData);
                got++;
            end
        end
        // Nothing past a taken branch or the final loop may retire
        repeat (DrainCycles) begin
            @(negedge clk);
            if (retireValid) begin
                $display("%s: unexpected extra retire of x%0d", testName[t], retireRd);
                errorCount++;
            end
        end
        holdEnable = 1'b0;
        checkA0(testName[t], expA0[t], a0);
    endtask

    // Random hold stretches of 1 to 4 cycles
    initial begin : holdDriver
        int left;
        hold = 1'b0;
        left = 0;
        void'($urandom(966));
        forever begin
            @(posedge clk);
            #5;
            if (!holdEnable) begin
                left = 0;
            end else if (left == 0 && $urandom % 3 == 0) begin
                left = 1 + int'($urandom % 4);
            end
            hold = (left > 0);
            if (left > 0) begin
                left--;
            end
        end
    end

    initial begin : watchdog
        wait (watchLimit > 0);
        repeat (watchLimit) @(posedge clk);
        $display("Watchdog: core stopped retiring, run ended after %0d cycles", watchLimit);
        $display("Summary: %0d retires checked, %0d errors", retireChecks, errorCount);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int total;
        rstN         = 1'b0;
        romWe        = 1'b0;
        romAddr      = '0;
        romData      = '0;
        holdEnable   = 1'b0;
        errorCount   = 0;
        retireChecks = 0;
        watchLimit   = 0;
        buildTable();
        total = 0;
        for (int t = 0; t < NumTests; t++) begin
            total += progLen[t];
        end
        // Each test also spends its ROM load, reset and drain cycles
        watchLimit = total * 20 + 100 + NumTests * (`IMEM_DEPTH + DrainCycles + 4);
        for (int t = 0; t < NumTests; t++) begin
            loadAndReset(t);
            runProgram(t);
        end
        $display("Summary: %0d retires checked, %0d errors", retireChecks, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
